// File: icache.f
+incdir+include
verilog/icache_pkg.sv
verilog/icache_way_ram.sv
verilog/icache_lookup.sv
verilog/icache_refill.sv
verilog/icache_fence.sv
verilog/icache_top.sv
sim/icache_tb.sv

// File: include/icache_settings.svh
// ======================================
// Instruction cache geometry and
// replacement LFSR seed
// ======================================

`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// Geometry
`define ICACHE_WAYS      2
`define ICACHE_SETS      16
`define ICACHE_INDEX_W   4
`define ICACHE_OFFSET_W  3
`define ICACHE_ADDR_W    32
`define ICACHE_LINE_W    64

// Nonzero reset value of the replacement LFSR
`define ICACHE_LFSR_SEED 7'h5b

`endif

// File: sim/icache_tb.sv
// ======================================
// Instruction cache testbench with memory
// model, stimulus table, checks, watchdog
// ======================================

`timescale 1ns/10ps
`default_nettype none

`include "icache_settings.svh"

module icache_tb
  import icache_pkg::*;
();

  localparam int CLK_PERIOD    = 20;
  localparam int NUM_ROWS      = 25;
  localparam int EITHER_MISSES = 1;
  localparam int WATCHDOG_NS   = (NUM_ROWS * 200 + 20) * CLK_PERIOD;

  localparam logic [1:0] OP_FETCH   = 2'd0;
  localparam logic [1:0] OP_BURST   = 2'd1;
  localparam logic [1:0] OP_FENCE   = 2'd2;
  localparam logic [1:0] EXP_MISS   = 2'd0;
  localparam logic [1:0] EXP_HIT    = 2'd1;
  localparam logic [1:0] EXP_EITHER = 2'd2;

  typedef struct packed {
    logic [1:0] op;
    paddr_t     addr;
    paddr_t     addr_b;
    logic [1:0] exp_hit;
    logic [1:0] exp_reqs;
  } row_t;

  logic   clk;
  logic   rst;
  logic   fetch_en;
  paddr_t fetch_addr;
  logic   fetch_ready;
  logic   resp_valid;
  paddr_t resp_addr;
  line_t  resp_data;
  logic   ic_hit;
  logic   ic_miss;
  logic   mem_req_valid;
  paddr_t mem_req_addr;
  logic   mem_req_ready;
  logic   mem_resp_valid;
  line_t  mem_resp_data;
  logic   mem_resp_ready;
  logic   fence_req_valid;
  logic   fence_req_ready;
  logic   fence_resp_valid;
  logic   fence_resp_ready;

  row_t        rows [NUM_ROWS];
  int          req_count;
  paddr_t      last_req_addr;
  logic [31:0] lcg_state;

  icache_top UUT (
    .clk              (clk),
    .rst              (rst),
    .fetch_en         (fetch_en),
    .fetch_addr       (fetch_addr),
    .fetch_ready      (fetch_ready),
    .resp_valid       (resp_valid),
    .resp_addr        (resp_addr),
    .resp_data        (resp_data),
    .ic_hit           (ic_hit),
    .ic_miss          (ic_miss),
    .mem_req_valid    (mem_req_valid),
    .mem_req_addr     (mem_req_addr),
    .mem_req_ready    (mem_req_ready),
    .mem_resp_valid   (mem_resp_valid),
    .mem_resp_data    (mem_resp_data),
    .mem_resp_ready   (mem_resp_ready),
    .fence_req_valid  (fence_req_valid),
    .fence_req_ready  (fence_req_ready),
    .fence_resp_valid (fence_resp_valid),
    .fence_resp_ready (fence_resp_ready)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // ======================================
  // Helpers
  function automatic paddr_t line_base(input paddr_t addr);
    return {addr[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W], {`ICACHE_OFFSET_W{1'b0}}};
  endfunction

  // Memory content is the line address, then its inverse
  function automatic line_t mem_line(input paddr_t addr);
    paddr_t base;
    base = line_base(addr);
    return {base, ~base};
  endfunction

  function automatic int unsigned next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16];
  endfunction

  task automatic report_error(input string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic wait_fetch_ready();
    while (!fetch_ready) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic check_hit_response(input paddr_t addr);
    assert (resp_valid && ic_hit && !ic_miss)
      else report_error($sformatf("no hit response for %h", addr));
    assert (resp_data == mem_line(addr))
      else report_error($sformatf("data %h, expected %h", resp_data, mem_line(addr)));
    assert (resp_addr == line_base(addr))
      else report_error($sformatf("resp_addr %h, expected %h", resp_addr, line_base(addr)));
  endtask

  // ======================================
  // Operations
  task automatic run_fetch(input paddr_t addr, output logic hit);
    int waited;
    waited = 0;
    wait_fetch_ready();
    fetch_en   = 1'b1;
    fetch_addr = addr;
    @(posedge clk);
    #1;
    fetch_en = 1'b0;
    @(negedge clk);
    while (!resp_valid) begin
      waited++;
      @(negedge clk);
    end
    hit = ic_hit;
    assert (ic_hit != ic_miss) else report_error("ic_hit and ic_miss disagree");
    assert (resp_data == mem_line(addr))
      else report_error($sformatf("data %h, expected %h", resp_data, mem_line(addr)));
    assert (resp_addr == line_base(addr))
      else report_error($sformatf("resp_addr %h, expected %h", resp_addr, line_base(addr)));
    assert (!hit || waited == 0)
      else report_error($sformatf("hit answered %0d cycles late", waited));
    @(posedge clk);
    #1;
  endtask

  // Second fetch issued in the cycle the first one answers
  task automatic run_burst(input paddr_t addr_a, input paddr_t addr_b);
    wait_fetch_ready();
    fetch_en   = 1'b1;
    fetch_addr = addr_a;
    @(posedge clk);
    #1;
    assert (fetch_ready) else report_error("fetch_ready dropped during a hit burst");
    fetch_addr = addr_b;
    @(negedge clk);
    check_hit_response(addr_a);
    @(posedge clk);
    #1;
    fetch_en = 1'b0;
    @(negedge clk);
    check_hit_response(addr_b);
    @(posedge clk);
    #1;
  endtask

  task automatic run_fence();
    int cycles;
    cycles = 0;
    fence_req_valid = 1'b1;
    while (!fence_req_ready) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
    fence_req_valid = 1'b0;
    assert (!fence_req_ready) else report_error("fence_req_ready high with a fence pending");
    while (!fence_resp_valid) begin
      assert (!fetch_ready) else report_error("fetch_ready high during a fence sweep");
      cycles++;
      @(posedge clk);
      #1;
    end
    assert (cycles == `ICACHE_SETS)
      else report_error($sformatf("fence took %0d cycles, expected %0d", cycles, `ICACHE_SETS));
    assert (!fetch_ready) else report_error("fetch_ready high before fence response");
    fence_resp_ready = 1'b1;
    @(posedge clk);
    #1;
    fence_resp_ready = 1'b0;
    assert (!fence_resp_valid) else report_error("fence response held after handshake");
  endtask

  // ======================================
  // Stimulus table
  // Set 0 holds 1000, 2000 and 3000; 1048 is set 9
  task automatic load_rows();
    rows[0]  = row_t'{OP_FETCH, 32'h0000_1004, 32'h0000_0000, EXP_MISS, 2'd1};
    rows[1]  = row_t'{OP_FETCH, 32'h0000_1000, 32'h0000_0000, EXP_HIT, 2'd0};
    rows[2]  = row_t'{OP_FETCH, 32'h0000_1006, 32'h0000_0000, EXP_HIT, 2'd0};
    rows[3]  = row_t'{OP_FETCH, 32'h0000_1048, 32'h0000_0000, EXP_MISS, 2'd1};
    rows[4]  = row_t'{OP_BURST, 32'h0000_1000, 32'h0000_104c, EXP_HIT, 2'd0};
    rows[5]  = row_t'{OP_FETCH, 32'h0000_2000, 32'h0000_0000, EXP_MISS, 2'd1};
    rows[6]  = row_t'{OP_FETCH, 32'h0000_1002, 32'h0000_0000, EXP_HIT, 2'd0};
    rows[7]  = row_t'{OP_FETCH, 32'h0000_2004, 32'h0000_0000, EXP_HIT, 2'd0};
    rows[8]  = row_t'{OP_FETCH, 32'h0000_3000, 32'h0000_0000, EXP_MISS, 2'd1};
    rows[9]  = row_t'{OP_FETCH, 32'h0000_3007, 32'h0000_0000, EXP_HIT, 2'd0};
    rows[10] = row_t'{OP_FETCH, 32'h0000_1000, 32'h0000_0000, EXP_EITHER, 2'd0};
    rows[11] = row_t'{OP_FETCH, 32'h0000_2000, 32'h0000_0000, EXP_EITHER, 2'd0};
    rows[12] = row_t'{OP_FENCE, 32'h0000_0000, 32'h0000_0000, EXP_HIT, 2'd0};
    rows[13] = row_t'{OP_FETCH, 32'h0000_1048, 32'h0000_0000, EXP_MISS, 2'd1};
    rows[14] = row_t'{OP_FETCH, 32'h0000_2000, 32'h0000_0000, EXP_MISS, 2'd1};
    rows[15] = row_t'{OP_FETCH, 32'h0000_3000, 32'h0000_0000, EXP_MISS, 2'd1};
    rows[16] = row_t'{OP_FETCH, 32'h0000_104a, 32'h0000_0000, EXP_HIT, 2'd0};
    rows[17] = row_t'{OP_FETCH, 32'h0000_2003, 32'h0000_0000, EXP_HIT, 2'd0};
    rows[18] = row_t'{OP_FETCH, 32'h0000_3004, 32'h0000_0000, EXP_HIT, 2'd0};
    rows[19] = row_t'{OP_FETCH, 32'h8000_00fc, 32'h0000_0000, EXP_MISS, 2'd1};
    rows[20] = row_t'{OP_BURST, 32'h8000_00f8, 32'h0000_2000, EXP_HIT, 2'd0};
    rows[21] = row_t'{OP_FETCH, 32'h0000_4010, 32'h0000_0000, EXP_MISS, 2'd1};
    rows[22] = row_t'{OP_FENCE, 32'h0000_0000, 32'h0000_0000, EXP_HIT, 2'd0};
    rows[23] = row_t'{OP_FETCH, 32'h0000_4014, 32'h0000_0000, EXP_MISS, 2'd1};
    rows[24] = row_t'{OP_FETCH, 32'h0000_4010, 32'h0000_0000, EXP_HIT, 2'd0};
  endtask

  // ======================================
  // Memory model with random stalls
  initial begin : mem_model
    paddr_t      addr;
    int unsigned wait_cycles;
    lcg_state      = 32'hfbaf_d066;
    req_count      = 0;
    last_req_addr  = '0;
    mem_req_ready  = 1'b0;
    mem_resp_valid = 1'b0;
    mem_resp_data  = '0;
    forever begin
      @(posedge clk);
      #1;
      if (mem_req_valid) begin
        addr = mem_req_addr;
        assert (addr == line_base(addr))
          else report_error($sformatf("request address %h not line aligned", addr));
        wait_cycles = next_random() % 4;
        repeat (wait_cycles) begin
          @(posedge clk);
          #1;
          assert (mem_req_valid && mem_req_addr == addr)
            else report_error("memory request dropped under back-pressure");
        end
        mem_req_ready = 1'b1;
        @(posedge clk);
        #1;
        mem_req_ready = 1'b0;
        assert (!mem_req_valid && mem_resp_ready)
          else report_error("mem_resp_ready not raised after the request handshake");
        req_count++;
        last_req_addr = addr;
        wait_cycles = next_random() % 4;
        repeat (wait_cycles) begin
          @(posedge clk);
          #1;
        end
        mem_resp_valid = 1'b1;
        mem_resp_data  = mem_line(addr);
        while (!mem_resp_ready) begin
          @(posedge clk);
          #1;
        end
        @(posedge clk);
        #1;
        mem_resp_valid = 1'b0;
      end
    end
  end

  // ======================================
  // Main sequence
  initial begin : stimulus
    logic got_hit;
    int   reqs_before;
    int   exp_reqs;
    int   either_misses;
    rst              = 1'b1;
    fetch_en         = 1'b0;
    fetch_addr       = '0;
    fence_req_valid  = 1'b0;
    fence_resp_ready = 1'b0;
    either_misses    = 0;
    load_rows();
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    assert (!fetch_ready && !resp_valid && !ic_hit && !ic_miss && !mem_req_valid &&
            !mem_resp_ready && !fence_resp_valid)
      else report_error("outputs not idle after reset");
    @(posedge clk);
    #1;
    assert (fetch_ready) else report_error("fetch_ready did not rise after reset");

    for (int r = 0; r < NUM_ROWS; r++) begin
      reqs_before = req_count;
      exp_reqs    = rows[r].exp_reqs;
      case (rows[r].op)
        OP_FENCE: run_fence();
        OP_BURST: run_burst(rows[r].addr, rows[r].addr_b);
        default: begin
          run_fetch(rows[r].addr, got_hit);
          if (rows[r].exp_hit == EXP_EITHER) begin
            exp_reqs = got_hit ? 0 : 1;
            if (!got_hit) begin
              either_misses++;
            end
          end else begin
            assert (got_hit == rows[r].exp_hit[0])
              else report_error($sformatf("row %0d hit %0b, expected %0b", r, got_hit,
                                          rows[r].exp_hit[0]));
          end
          if (!got_hit) begin
            assert (last_req_addr == line_base(rows[r].addr))
              else report_error($sformatf("row %0d requested %h, expected %h", r,
                                          last_req_addr, line_base(rows[r].addr)));
          end
        end
      endcase
      assert (req_count - reqs_before == exp_reqs)
        else report_error($sformatf("row %0d made %0d requests, expected %0d", r,
                                    req_count - reqs_before, exp_reqs));
    end

    // One of the two older lines in the set was evicted
    assert (either_misses == EITHER_MISSES)
      else report_error($sformatf("%0d misses on refetch, expected %0d", either_misses,
                                  EITHER_MISSES));
    $display("TESTBENCH PASSED");
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Timeout: the stimulus table did not complete within %0d ns", WATCHDOG_NS);
    $display("TESTBENCH FAILED");
    $fatal(1);
  end

endmodule

`default_nettype wire

// File: verilog/icache_fence.sv
// ======================================
// Fence handshake and invalidation sweep
// ======================================

`timescale 1ns/10ps
`default_nettype none

`include "icache_settings.svh"

module icache_fence
  import icache_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     fence_req_valid,
  input  logic     pipe_idle,
  input  logic     fence_resp_ready,
  output logic     fence_req_ready,
  output logic     fence_resp_valid,
  output logic     fence_busy,
  output logic     clr_en,
  output set_idx_t clr_index
);

  logic                     pending_q;
  logic [`ICACHE_INDEX_W:0] sweep_q;
  logic                     sweep_done;

  // Top bit set once every set has been cleared
  assign sweep_done = sweep_q[`ICACHE_INDEX_W];

  always_ff @(posedge clk) begin
    if (rst) begin
      pending_q <= 1'b0;
      sweep_q   <= '0;
    end else begin
      if (fence_req_valid & fence_req_ready) begin
        pending_q <= 1'b1;
      end else if (fence_resp_valid & fence_resp_ready) begin
        pending_q <= 1'b0;
      end
      if (fence_resp_valid & fence_resp_ready) begin
        sweep_q <= '0;
      end else if (clr_en) begin
        sweep_q <= sweep_q + 1'b1;
      end
    end
  end

  assign fence_req_ready  = ~pending_q & pipe_idle;
  assign fence_resp_valid = sweep_done;
  assign fence_busy       = pending_q;
  assign clr_en           = pending_q & ~sweep_done;
  assign clr_index        = sweep_q[`ICACHE_INDEX_W-1:0];

endmodule

`default_nettype wire

// File: verilog/icache_lookup.sv
// ======================================
// Fetch acceptance, compare stage and
// fetch response mux
// ======================================

`timescale 1ns/10ps
`default_nettype none

`include "icache_settings.svh"

module icache_lookup
  import icache_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     fetch_en,
  input  paddr_t                   fetch_addr,
  input  logic                     refill_busy,
  input  logic                     fence_busy,
  input  logic                     fill_done,
  input  line_t                    fill_data,
  input  logic [`ICACHE_WAYS-1:0]  rd_valid,
  input  tag_t [`ICACHE_WAYS-1:0]  rd_tag,
  input  line_t [`ICACHE_WAYS-1:0] rd_data,
  output logic                     fetch_ready,
  output logic                     rd_en,
  output set_idx_t                 rd_index,
  output logic                     resp_valid,
  output paddr_t                   resp_addr,
  output line_t                    resp_data,
  output logic                     ic_hit,
  output logic                     ic_miss,
  output logic                     miss_start,
  output paddr_t                   miss_addr,
  output logic [`ICACHE_WAYS-1:0]  miss_valid,
  output logic                     pipe_idle
);

  logic                    ready_q;
  logic                    s1_valid;
  paddr_t                  s1_addr;
  tag_t                    s1_tag;
  logic [`ICACHE_WAYS-1:0] tag_match;
  logic                    hit;
  line_t                   match_data;

  // ======================================
  // Read stage
  assign rd_en    = fetch_en & fetch_ready;
  assign rd_index = fetch_addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];

  always_ff @(posedge clk) begin
    if (rst) begin
      ready_q  <= 1'b0;
      s1_valid <= 1'b0;
    end else begin
      ready_q  <= 1'b1;
      s1_valid <= rd_en;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      s1_addr <= fetch_addr;
    end
  end

  // ======================================
  // Compare stage
  assign s1_tag = s1_addr[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W+`ICACHE_INDEX_W];

  always_comb begin
    match_data = '0;
    for (int i = 0; i < `ICACHE_WAYS; i++) begin
      tag_match[i] = rd_valid[i] & (rd_tag[i] == s1_tag);
      match_data   = match_data | (rd_data[i] & {$bits(line_t){tag_match[i]}});
    end
  end

  assign hit        = s1_valid & (|tag_match);
  assign miss_start = s1_valid & ~(|tag_match);
  assign miss_addr  = s1_addr;
  assign miss_valid = rd_valid;

  // Ready drops in the miss cycle itself, before refill_busy rises
  assign fetch_ready = ready_q & ~miss_start & ~refill_busy & ~fence_busy;
  assign pipe_idle   = ~s1_valid & ~rd_en & ~refill_busy;

  // ======================================
  // Fetch response
  assign resp_addr = {s1_addr[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W], {`ICACHE_OFFSET_W{1'b0}}};

  always_comb begin
    resp_valid = 1'b0;
    resp_data  = '0;
    ic_hit     = 1'b0;
    ic_miss    = 1'b0;
    if (hit) begin
      resp_valid = 1'b1;
      resp_data  = match_data;
      ic_hit     = 1'b1;
    end else if (fill_done) begin
      resp_valid = 1'b1;
      resp_data  = fill_data;
      ic_miss    = 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: verilog/icache_pkg.sv
// ======================================
// Instruction cache vector types and
// refill state encoding
// ======================================

`default_nettype none

`include "icache_settings.svh"

package icache_pkg;

  typedef logic [`ICACHE_ADDR_W-1:0] paddr_t;
  typedef logic [`ICACHE_INDEX_W-1:0] set_idx_t;

  // Address bits above index and offset
  typedef logic [`ICACHE_ADDR_W-`ICACHE_INDEX_W-`ICACHE_OFFSET_W-1:0] tag_t;

  typedef logic [`ICACHE_LINE_W-1:0] line_t;
  typedef logic [$clog2(`ICACHE_WAYS)-1:0] way_id_t;

  typedef enum logic [1:0] {
    REFILL_IDLE,
    REFILL_REQ,
    REFILL_WAIT
  } refill_state_t;

endpackage

`default_nettype wire

// File: verilog/icache_refill.sv
// ======================================
// Miss FSM, memory handshakes, victim
// selection and line write
// ======================================

`timescale 1ns/10ps
`default_nettype none

`include "icache_settings.svh"

module icache_refill
  import icache_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    miss_start,
  input  paddr_t                  miss_addr,
  input  logic [`ICACHE_WAYS-1:0] miss_valid,
  input  logic                    mem_req_ready,
  input  logic                    mem_resp_valid,
  input  line_t                   mem_resp_data,
  output logic                    refill_busy,
  output logic                    mem_req_valid,
  output paddr_t                  mem_req_addr,
  output logic                    mem_resp_ready,
  output logic                    fill_done,
  output line_t                   fill_data,
  output logic [`ICACHE_WAYS-1:0] wr_en,
  output set_idx_t                wr_index,
  output tag_t                    wr_tag,
  output line_t                   wr_data
);

  refill_state_t state_q;
  refill_state_t state_d;
  logic [6:0]    lfsr_q;
  logic          lfsr_fb;
  way_id_t       victim;
  way_id_t       victim_q;
  paddr_t        addr_q;

  // ======================================
  // Miss FSM
  always_comb begin
    state_d = state_q;
    case (state_q)
      REFILL_IDLE: begin
        if (miss_start) begin
          state_d = REFILL_REQ;
        end
      end
      REFILL_REQ: begin
        if (mem_req_ready) begin
          state_d = REFILL_WAIT;
        end
      end
      REFILL_WAIT: begin
        if (mem_resp_valid) begin
          state_d = REFILL_IDLE;
        end
      end
      default: state_d = REFILL_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= REFILL_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign refill_busy    = (state_q != REFILL_IDLE);
  assign mem_req_valid  = (state_q == REFILL_REQ);
  assign mem_resp_ready = (state_q == REFILL_WAIT);
  assign mem_req_addr   = {addr_q[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W], {`ICACHE_OFFSET_W{1'b0}}};

  assign fill_done = mem_resp_valid & mem_resp_ready;
  assign fill_data = mem_resp_data;

  // ======================================
  // Replacement
  assign lfsr_fb = lfsr_q[6] ^ lfsr_q[5];

  always_ff @(posedge clk) begin
    if (rst) begin
      lfsr_q <= `ICACHE_LFSR_SEED;
    end else if (fill_done) begin
      lfsr_q <= {lfsr_q[5:0], lfsr_fb};
    end
  end

  // Highest invalid way first, random otherwise
  always_comb begin
    victim = lfsr_q[$bits(way_id_t)-1:0];
    for (int i = 0; i < `ICACHE_WAYS; i++) begin
      if (!miss_valid[i]) begin
        victim = way_id_t'(i);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (miss_start) begin
      victim_q <= victim;
      addr_q   <= miss_addr;
    end
  end

  // ======================================
  // Line write
  always_comb begin
    for (int i = 0; i < `ICACHE_WAYS; i++) begin
      wr_en[i] = fill_done & (victim_q == way_id_t'(i));
    end
  end

  assign wr_index = addr_q[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
  assign wr_tag   = addr_q[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W+`ICACHE_INDEX_W];
  assign wr_data  = mem_resp_data;

endmodule

`default_nettype wire

// File: verilog/icache_top.sv
// ======================================
// Two-way instruction cache top
// ======================================

`timescale 1ns/10ps
`default_nettype none

`include "icache_settings.svh"

module icache_top
  import icache_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  logic   fetch_en,
  input  paddr_t fetch_addr,
  output logic   fetch_ready,
  output logic   resp_valid,
  output paddr_t resp_addr,
  output line_t  resp_data,
  output logic   ic_hit,
  output logic   ic_miss,
  output logic   mem_req_valid,
  output paddr_t mem_req_addr,
  input  logic   mem_req_ready,
  input  logic   mem_resp_valid,
  input  line_t  mem_resp_data,
  output logic   mem_resp_ready,
  input  logic   fence_req_valid,
  output logic   fence_req_ready,
  output logic   fence_resp_valid,
  input  logic   fence_resp_ready
);

  logic                     rd_en;
  set_idx_t                 rd_index;
  logic [`ICACHE_WAYS-1:0]  rd_valid;
  tag_t [`ICACHE_WAYS-1:0]  rd_tag;
  line_t [`ICACHE_WAYS-1:0] rd_data;
  logic                     miss_start;
  paddr_t                   miss_addr;
  logic [`ICACHE_WAYS-1:0]  miss_valid;
  logic                     refill_busy;
  logic                     fill_done;
  line_t                    fill_data;
  logic [`ICACHE_WAYS-1:0]  wr_en;
  set_idx_t                 wr_index;
  tag_t                     wr_tag;
  line_t                    wr_data;
  logic                     fence_busy;
  logic                     clr_en;
  set_idx_t                 clr_index;
  logic                     pipe_idle;

  icache_lookup u_lookup (
    .clk         (clk),
    .rst         (rst),
    .fetch_en    (fetch_en),
    .fetch_addr  (fetch_addr),
    .refill_busy (refill_busy),
    .fence_busy  (fence_busy),
    .fill_done   (fill_done),
    .fill_data   (fill_data),
    .rd_valid    (rd_valid),
    .rd_tag      (rd_tag),
    .rd_data     (rd_data),
    .fetch_ready (fetch_ready),
    .rd_en       (rd_en),
    .rd_index    (rd_index),
    .resp_valid  (resp_valid),
    .resp_addr   (resp_addr),
    .resp_data   (resp_data),
    .ic_hit      (ic_hit),
    .ic_miss     (ic_miss),
    .miss_start  (miss_start),
    .miss_addr   (miss_addr),
    .miss_valid  (miss_valid),
    .pipe_idle   (pipe_idle)
  );

  icache_refill u_refill (
    .clk            (clk),
    .rst            (rst),
    .miss_start     (miss_start),
    .miss_addr      (miss_addr),
    .miss_valid     (miss_valid),
    .mem_req_ready  (mem_req_ready),
    .mem_resp_valid (mem_resp_valid),
    .mem_resp_data  (mem_resp_data),
    .refill_busy    (refill_busy),
    .mem_req_valid  (mem_req_valid),
    .mem_req_addr   (mem_req_addr),
    .mem_resp_ready (mem_resp_ready),
    .fill_done      (fill_done),
    .fill_data      (fill_data),
    .wr_en          (wr_en),
    .wr_index       (wr_index),
    .wr_tag         (wr_tag),
    .wr_data        (wr_data)
  );

  icache_fence u_fence (
    .clk              (clk),
    .rst              (rst),
    .fence_req_valid  (fence_req_valid),
    .pipe_idle        (pipe_idle),
    .fence_resp_ready (fence_resp_ready),
    .fence_req_ready  (fence_req_ready),
    .fence_resp_valid (fence_resp_valid),
    .fence_busy       (fence_busy),
    .clr_en           (clr_en),
    .clr_index        (clr_index)
  );

  // One storage block per way
  for (genvar g = 0; g < `ICACHE_WAYS; g++) begin : g_way
    icache_way_ram u_way (
      .clk       (clk),
      .rst       (rst),
      .rd_en     (rd_en),
      .rd_index  (rd_index),
      .wr_en     (wr_en[g]),
      .wr_index  (wr_index),
      .wr_tag    (wr_tag),
      .wr_data   (wr_data),
      .clr_en    (clr_en),
      .clr_index (clr_index),
      .rd_valid  (rd_valid[g]),
      .rd_tag    (rd_tag[g]),
      .rd_data   (rd_data[g])
    );
  end

endmodule

`default_nettype wire

// File: verilog/icache_way_ram.sv
// ======================================
// One cache way: valid bits, tag and
// data arrays with a registered read
// ======================================

`timescale 1ns/10ps
`default_nettype none

`include "icache_settings.svh"

module icache_way_ram
  import icache_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     rd_en,
  input  set_idx_t rd_index,
  input  logic     wr_en,
  input  set_idx_t wr_index,
  input  tag_t     wr_tag,
  input  line_t    wr_data,
  input  logic     clr_en,
  input  set_idx_t clr_index,
  output logic     rd_valid,
  output tag_t     rd_tag,
  output line_t    rd_data
);

  logic [`ICACHE_SETS-1:0] valid_q;
  tag_t                    tag_mem  [`ICACHE_SETS];
  line_t                   data_mem [`ICACHE_SETS];

  // A fill wins over a clear of the same set
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else begin
      if (clr_en) begin
        valid_q[clr_index] <= 1'b0;
      end
      if (wr_en) begin
        valid_q[wr_index] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      tag_mem[wr_index]  <= wr_tag;
      data_mem[wr_index] <= wr_data;
    end
  end

  // Registered read port
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_valid <= 1'b0;
    end else if (rd_en) begin
      rd_valid <= valid_q[rd_index];
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_tag  <= tag_mem[rd_index];
      rd_data <= data_mem[rd_index];
    end
  end

endmodule

`default_nettype wire
